//--- sprites.hex
// each line: @ word address (frame * 400h + byte address), then bytes from there on
// frames 0-5 idle, 6-9 sleeping, 10-14 eating, 15-21 teaching, 22-29 dead
@0000 01 02 03 04 05 06 07 08
@0400 09 0a 0b 0c 0d 0e 0f 10
@0800 11 12 13 14 15 16 17 18
@0c00 19 1a 1b 1c 1d 1e 1f 20
@1000 21 22 23 24 25 26 27 28
@1400 29 2a 2b 2c 2d 2e 2f 30
@1800 31 32 33 34 35 36 37 38
@1c00 39 3a 3b 3c 3d 3e 3f 40
@2000 41 42 43 44 45 46 47 48
@2400 49 4a 4b 4c 4d 4e 4f 50
@2800 51 52 53 54 55 56 57 58
@2c00 59 5a 5b 5c 5d 5e 5f 60
@3000 61 62 63 64 65 66 67 68
@3400 69 6a 6b 6c 6d 6e 6f 70
@3800 71 72 73 74 75 76 77 78
@3c00 79 7a 7b 7c 7d 7e 7f 80
@4000 81 82 83 84 85 86 87 88
@4400 89 8a 8b 8c 8d 8e 8f 90
@4800 91 92 93 94 95 96 97 98
@4c00 99 9a 9b 9c 9d 9e 9f a0
@5000 a1 a2 a3 a4 a5 a6 a7 a8
@5400 a9 aa ab ac ad ae af b0
@5800 b1 b2 b3 b4 b5 b6 b7 b8
@5c00 b9 ba bb bc bd be bf c0
@6000 c1 c2 c3 c4 c5 c6 c7 c8
@6400 c9 ca cb cc cd ce cf d0
@6800 d1 d2 d3 d4 d5 d6 d7 d8
@6c00 d9 da db dc dd de df e0
@7000 e1 e2 e3 e4 e5 e6 e7 e8
@7400 e9 ea eb ec ed ee ef f0
// pixels under the happiness bar, covered by the overlay except when dead
@0041 ff ff ff ff ff
@0c41 ff 7e 3c 18 ff
@1841 aa aa aa aa aa
@2841 55 55 55 55 55
@3c41 0f 0f 0f 0f 0f
@5841 61 62 63 64 65
@5c41 71 72 73 74 75
@6041 81 82 83 84 85
@6441 91 92 93 94 95
@6841 a1 a2 a3 a4 a5
@6c41 b1 b2 b3 b4 b5
@7041 c1 c2 c3 c4 c5
@7441 d1 d2 d3 d4 d5
// hunger and sleep bar columns, plus bytes next to the segments
@0c91 33 33 33 33 33
@0d01 aa
@0d07 55
@5891 e1 e2 e3 e4 e5
@6891 f1 f2 f3 f4 f5
@58e1 1e 2e 3e 4e 5e
@74e1 1d 2d 3d 4d 5d
@5940 9c
@5947 c9
@3c40 77

//--- src.f
hdl/pet_display_pkg.sv
hdl/frame_sequencer.sv
hdl/sprite_rom.sv
hdl/status_overlay.sv
hdl/pet_display.sv
bench/pet_display_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pet_display_tb
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/pet_display_tb.sv
`timescale 1ns/1ps

module pet_display_tb
    import pet_display_pkg::*;
();

    localparam int TB_TICK_BITS = 6;
    localparam int TICK_PERIOD  = 1 << TB_TICK_BITS;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;

    localparam logic [31:0] LFSR_SEED = 32'h2659;
    localparam logic [31:0] LFSR_TAPS = 32'hA3000000;

    localparam int RAND_CYCLES = 64;
    localparam int ANIM_TICKS  = 16;  // long enough for the 7-frame animation to wrap
    localparam int ANIM_CYCLES = ANIM_TICKS * TICK_PERIOD;
    localparam int MOOD_CASES  = 7;
    localparam int MOOD_HOLD   = 16;
    localparam int BAR_VALUES  = 6;
    localparam int BAR_FIRST   = HAPPY_COL * COL_BYTES;
    localparam int BAR_SWEEP   = (SLEEP_COL + BAR_COLS) * COL_BYTES - BAR_FIRST;
    localparam int TEST_CYCLES = RESET_CYCLES + RAND_CYCLES + 3 * ANIM_CYCLES + FRAME_BYTES
                               + MOOD_CASES * MOOD_HOLD + 2 * BAR_VALUES * BAR_SWEEP + 8;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 256) * CLK_PERIOD;

    typedef struct packed {
        logic              check;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        exp;
    } check_item_t;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] byte_addr;
    pet_state_e        state;
    stats_t            stats;
    logic [7:0]        pixel_byte;

    logic [7:0]  sprite [0:ROM_DEPTH-1];  // own copy of the sprite data
    logic [31:0] lfsr;
    int          edge_cnt;    // counts rising edges from reset release in step with the tick counter
    int          mood_model;  // idle frame the DUT has registered
    int          pushed_cnt = 0;
    int          checked_cnt = 0;
    check_item_t exp_q [$];

    pet_display #(
        .TICK_BITS (TB_TICK_BITS)
    ) dut (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_byte_addr  (byte_addr),
        .i_state      (state),
        .i_stats      (stats),
        .o_pixel_byte (pixel_byte)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            edge_cnt   <= 0;
            mood_model <= 0;
        end else begin
            edge_cnt   <= edge_cnt + 1;
            mood_model <= mood_of(stats);  // mood follows the stats one cycle late
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] x);
        if (x[0]) begin
            return (x >> 1) ^ LFSR_TAPS;
        end
        return x >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // half of the picks land in column 0 where every frame has its own bytes
    function automatic logic [ADDR_W-1:0] random_addr();
        logic [31:0] r;
        r = rand_bits(1);
        if (r[0]) begin
            r = rand_bits(OFS_W);
        end else begin
            r = rand_bits(ADDR_W);
        end
        return r[ADDR_W-1:0];
    endfunction

    function automatic int mood_of(input stats_t s);
        int h;
        int g;
        int z;
        h = int'(s.happiness);
        g = int'(s.hunger);
        z = int'(s.sleep);
        if (h > 80 && g > 80 && z > 80) begin
            return 0;
        end else if (h < 10) begin
            return 2;
        end else if (g < 10) begin
            return 1;
        end else if (z < 10) begin
            return 5;
        end else if (h < 20 || g < 20 || z < 20) begin
            return 4;
        end
        return 3;
    endfunction

    function automatic logic [7:0] expected_byte(input logic [ADDR_W-1:0] addr,
                                                 input pet_state_e st, input stats_t s,
                                                 input int edges, input int mood);
        int ticks;
        int slow;
        int frame;
        int col;
        int ofs;
        int v;
        logic [FRAME_ID_W-1:0] fid;
        ticks = edges / TICK_PERIOD;
        slow  = (ticks + 1) / 2;  // slow animations step on ticks 1, 3, 5 and so on
        case (st)
            SLEEPING: frame = int'(SLEEP_BASE) + slow % SLEEP_FRAMES;
            EATING:   frame = int'(EAT_BASE) + slow % EAT_FRAMES;
            TEACHING: frame = int'(TEACH_BASE) + slow % TEACH_FRAMES;
            DEAD:     frame = int'(DEAD_BASE) + ticks % DEAD_FRAMES;
            default:  frame = int'(IDLE_BASE) + mood;
        endcase
        col = int'(addr) / COL_BYTES;
        ofs = int'(addr) % COL_BYTES;
        v   = -1;
        if (st != DEAD && ofs >= 1 && ofs <= BAR_SEGMENTS) begin
            if (col >= HAPPY_COL && col < HAPPY_COL + BAR_COLS) begin
                v = int'(s.happiness);
            end else if (col >= HUNGER_COL && col < HUNGER_COL + BAR_COLS) begin
                v = int'(s.hunger);
            end else if (col >= SLEEP_COL && col < SLEEP_COL + BAR_COLS) begin
                v = int'(s.sleep);
            end
        end
        if (v >= 0) begin
            if (v > 110 - 20 * ofs) begin
                return SEG_FULL;
            end else if (v > 100 - 20 * ofs) begin
                return SEG_HALF;
            end
            return 8'h00;
        end
        fid = FRAME_ID_W'(frame);
        return sprite[{fid, addr}];
    endfunction

    task automatic drive(input logic [ADDR_W-1:0] addr, input pet_state_e st, input stats_t s);
        check_item_t item;
        @(negedge clk);
        byte_addr  = addr;
        state      = st;
        stats      = s;
        item.check = 1'b1;
        item.addr  = addr;
        item.exp   = expected_byte(addr, st, s, edge_cnt, mood_model);
        exp_q.push_back(item);
        pushed_cnt++;
    endtask

    task automatic random_reads();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            drive(random_addr(), IDLE, {8'd50, 8'd50, 8'd50});
        end
    endtask

    task automatic slow_animations();
        pet_state_e slow_states [3];
        slow_states = '{SLEEPING, EATING, TEACHING};
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < ANIM_CYCLES; i++) begin
                drive(random_addr(), slow_states[k], {8'd60, 8'd60, 8'd60});
            end
        end
    endtask

    // the sweep also spans 16 ticks, so the dead animation wraps twice
    task automatic dead_sweep();
        for (int a = 0; a < FRAME_BYTES; a++) begin
            drive(ADDR_W'(a), DEAD, {8'd30, 8'd70, 8'd100});
        end
    endtask

    task automatic mood_rules();
        stats_t cases [MOOD_CASES];
        cases[0] = {8'd90, 8'd90, 8'd90};  // all high
        cases[1] = {8'd5, 8'd5, 8'd5};     // low happiness wins over the rest
        cases[2] = {8'd50, 8'd5, 8'd5};    // hunger before sleep
        cases[3] = {8'd50, 8'd50, 8'd5};
        cases[4] = {8'd15, 8'd50, 8'd50};
        cases[5] = {8'd80, 8'd90, 8'd90};  // 80 is not above 80
        cases[6] = {8'd85, 8'd85, 8'd19};
        for (int c = 0; c < MOOD_CASES; c++) begin
            for (int i = 0; i < MOOD_HOLD; i++) begin
                drive(ADDR_W'(i % COL_BYTES), IDLE, cases[c]);
            end
        end
    endtask

    task automatic bar_levels();
        logic [7:0] vals [BAR_VALUES];
        pet_state_e live [4];
        stats_t     s;
        vals = '{8'd0, 8'd5, 8'd15, 8'd45, 8'd85, 8'd95};
        live = '{IDLE, SLEEPING, EATING, TEACHING};
        for (int i = 0; i < BAR_VALUES; i++) begin
            s = {vals[i], vals[(i + 2) % BAR_VALUES], vals[(i + 4) % BAR_VALUES]};
            for (int a = 0; a < BAR_SWEEP; a++) begin
                drive(ADDR_W'(BAR_FIRST + a), live[i % 4], s);
            end
            for (int a = 0; a < BAR_SWEEP; a++) begin
                drive(ADDR_W'(BAR_FIRST + a), DEAD, s);  // raw sprite under the bars
            end
        end
    endtask

    // an item enters stage1 on the edge that samples its address and is due one edge later
    initial begin
        check_item_t stage1;
        check_item_t stage2;
        stage1 = '0;
        stage2 = '0;
        forever begin
            @(posedge clk);
            stage2 = stage1;
            if (exp_q.size() > 0) begin
                stage1 = exp_q.pop_front();
            end else begin
                stage1 = '0;
            end
            @(negedge clk);
            if (stage2.check) begin
                checked_cnt++;
                assert (pixel_byte == stage2.exp) else begin
                    $display("Fail at %0t ns: addr %h expected %h got %h",
                             $time, stage2.addr, stage2.exp, pixel_byte);
                    $display("TEST FAIL");
                    $fatal(1);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests had finished");
        $display("TEST FAIL");
        $fatal(1);
    end

    initial begin
        rst_n     = 1'b0;
        byte_addr = '0;
        state     = IDLE;
        stats     = '0;
        lfsr      = LFSR_SEED;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            sprite[ROM_ADDR_W'(i)] = 8'h00;
        end
        $readmemh(SPRITE_FILE, sprite);

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (pixel_byte == 8'h00) else begin
                $display("Fail at %0t ns: output %h during reset, expected 00",
                         $time, pixel_byte);
                $display("TEST FAIL");
                $fatal(1);
            end
        end
        rst_n = 1'b1;

        random_reads();
        slow_animations();
        dead_sweep();
        mood_rules();
        bar_levels();
        repeat (4) @(negedge clk);

        if (checked_cnt == pushed_cnt && pushed_cnt > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("only %0d of %0d bytes were compared", checked_cnt, pushed_cnt);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

//--- hdl/pet_display.sv
`timescale 1ns/1ps

module pet_display
    import pet_display_pkg::*;
#(
    parameter int TICK_BITS = 22  // frame tick every 2^TICK_BITS cycles
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic [ADDR_W-1:0] i_byte_addr,
    input  pet_state_e        i_state,
    input  stats_t            i_stats,
    output logic [7:0]        o_pixel_byte
);

    frame_req_t frame_req;  // combinational request for the current address
    rom_word_t  rom_word;   // one cycle later, sprite byte plus overlay info

    frame_sequencer #(
        .TICK_BITS (TICK_BITS)
    ) u_frame_sequencer (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_byte_addr (i_byte_addr),
        .i_state     (i_state),
        .i_stats     (i_stats),
        .o_req       (frame_req)
    );

    sprite_rom u_sprite_rom (
        .clk    (clk),
        .i_req  (frame_req),
        .o_word (rom_word)
    );

    // bars are drawn last so they sit on top of the sprite
    status_overlay u_status_overlay (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_word       (rom_word),
        .o_pixel_byte (o_pixel_byte)
    );

endmodule

//--- hdl/status_overlay.sv
`timescale 1ns/1ps

module status_overlay
    import pet_display_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  rom_word_t  i_word,
    output logic [7:0] o_pixel_byte
);

    logic [COL_W-1:0] col;
    logic [OFS_W-1:0] seg;
    logic             seg_ok;
    logic             in_happy;
    logic             in_hunger;
    logic             in_sleep;
    logic [7:0]       bar_val;
    logic [7:0]       next_byte;

    function automatic logic in_bar(input logic [COL_W-1:0] c, input int base);
        return int'(c) >= base && int'(c) < base + BAR_COLS;
    endfunction

    // segment 1 is the top of the bar and needs the highest value
    function automatic logic [7:0] seg_byte(input logic [7:0] v, input logic [OFS_W-1:0] s);
        int full_thr;
        int half_thr;
        full_thr = SEG_FULL_BASE - SEG_STEP * int'(s);
        half_thr = SEG_HALF_BASE - SEG_STEP * int'(s);
        if (int'(v) > full_thr) begin
            return SEG_FULL;
        end else if (int'(v) > half_thr) begin
            return SEG_HALF;
        end
        return 8'h00;
    endfunction

    assign col = i_word.byte_addr[ADDR_W-1:OFS_W];  // column is the address over 8
    assign seg = i_word.byte_addr[OFS_W-1:0];

    assign seg_ok    = i_word.show_bars && seg >= OFS_W'(1) && int'(seg) <= BAR_SEGMENTS;
    assign in_happy  = seg_ok && in_bar(col, HAPPY_COL);
    assign in_hunger = seg_ok && in_bar(col, HUNGER_COL);
    assign in_sleep  = seg_ok && in_bar(col, SLEEP_COL);

    always_comb begin
        bar_val   = 8'h00;
        next_byte = i_word.data;  // sprite byte passes through outside the bars
        if (in_happy) begin
            bar_val   = i_word.stats.happiness;
            next_byte = seg_byte(bar_val, seg);
        end else if (in_hunger) begin
            bar_val   = i_word.stats.hunger;
            next_byte = seg_byte(bar_val, seg);
        end else if (in_sleep) begin
            bar_val   = i_word.stats.sleep;
            next_byte = seg_byte(bar_val, seg);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pixel_byte <= 8'h00;
        end else begin
            o_pixel_byte <= next_byte;
        end
    end

endmodule

//--- hdl/sprite_rom.sv
`timescale 1ns/1ps

module sprite_rom
    import pet_display_pkg::*;
(
    input  logic       clk,
    input  frame_req_t i_req,
    output rom_word_t  o_word
);

    // all animation frames back to back, 1024 bytes each
    logic [7:0] rom [0:ROM_DEPTH-1];

    logic [ROM_ADDR_W-1:0] rd_addr;

    // frame number selects the 1 KiB page, the byte address the offset in it
    assign rd_addr = {i_req.frame_id, i_req.byte_addr};

    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = 8'h00;  // bytes missing from the sparse file stay blank
        end
        $readmemh(SPRITE_FILE, rom);
    end

    always_ff @(posedge clk) begin
        o_word.data      <= rom[rd_addr];
        o_word.byte_addr <= i_req.byte_addr;  // side fields stay aligned with the data
        o_word.show_bars <= i_req.show_bars;
        o_word.stats     <= i_req.stats;
    end

endmodule

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
    import pet_display_pkg::*;
#(
    parameter int TICK_BITS = 22
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic [ADDR_W-1:0] i_byte_addr,
    input  pet_state_e        i_state,
    input  stats_t            i_stats,
    output frame_req_t        o_req
);

    logic [TICK_BITS-1:0] tick_cnt;
    logic                 frame_tick;

    logic [IDX_W-1:0] idx_sleep;
    logic [IDX_W-1:0] idx_eat;
    logic [IDX_W-1:0] idx_teach;
    logic [IDX_W-1:0] idx_dead;
    logic [IDX_W-1:0] mood_idx;

    // the slow animations only step on every other tick
    logic ph_sleep;
    logic ph_eat;
    logic ph_teach;

    logic [IDX_W-1:0] frame_idx;
    logic [FRAME_ID_W-1:0] frame_base;

    function automatic logic [IDX_W-1:0] wrap_inc(input logic [IDX_W-1:0] idx,
                                                   input int count);
        if (int'(idx) == count - 1) begin
            return '0;
        end
        return idx + IDX_W'(1);
    endfunction

    assign frame_tick = &tick_cnt;  // counter wraps right after this cycle

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tick_cnt  <= '0;
            ph_sleep  <= 1'b0;
            ph_eat    <= 1'b0;
            ph_teach  <= 1'b0;
            idx_sleep <= '0;
            idx_eat   <= '0;
            idx_teach <= '0;
            idx_dead  <= '0;
        end else begin
            tick_cnt <= tick_cnt + TICK_BITS'(1);
            if (frame_tick) begin
                ph_sleep <= ~ph_sleep;
                ph_eat   <= ~ph_eat;
                ph_teach <= ~ph_teach;
                if (!ph_sleep) idx_sleep <= wrap_inc(idx_sleep, SLEEP_FRAMES);
                if (!ph_eat) idx_eat <= wrap_inc(idx_eat, EAT_FRAMES);
                if (!ph_teach) idx_teach <= wrap_inc(idx_teach, TEACH_FRAMES);
                idx_dead <= wrap_inc(idx_dead, DEAD_FRAMES);  // dead frames step every tick
            end
        end
    end

    // first rule that matches picks the idle frame
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mood_idx <= MOOD_CONTENT;
        end else if (i_stats.happiness > MOOD_HIGH && i_stats.hunger > MOOD_HIGH &&
                     i_stats.sleep > MOOD_HIGH) begin
            mood_idx <= MOOD_CONTENT;
        end else if (i_stats.happiness < MOOD_LOW) begin
            mood_idx <= MOOD_SAD;
        end else if (i_stats.hunger < MOOD_LOW) begin
            mood_idx <= MOOD_HUNGRY;
        end else if (i_stats.sleep < MOOD_LOW) begin
            mood_idx <= MOOD_TIRED;
        end else if (i_stats.happiness < MOOD_WARN || i_stats.hunger < MOOD_WARN ||
                     i_stats.sleep < MOOD_WARN) begin
            mood_idx <= MOOD_WORRIED;
        end else begin
            mood_idx <= MOOD_PLAIN;
        end
    end

    always_comb begin
        case (i_state)
            SLEEPING: begin
                frame_base = SLEEP_BASE;
                frame_idx  = idx_sleep;
            end
            EATING: begin
                frame_base = EAT_BASE;
                frame_idx  = idx_eat;
            end
            TEACHING: begin
                frame_base = TEACH_BASE;
                frame_idx  = idx_teach;
            end
            DEAD: begin
                frame_base = DEAD_BASE;
                frame_idx  = idx_dead;
            end
            default: begin  // IDLE and any illegal code show the mood frame
                frame_base = IDLE_BASE;
                frame_idx  = mood_idx;
            end
        endcase
    end

    assign o_req.frame_id  = frame_base + FRAME_ID_W'(frame_idx);
    assign o_req.byte_addr = i_byte_addr;
    assign o_req.show_bars = (i_state != DEAD);  // no bars over the dead animation
    assign o_req.stats     = i_stats;

endmodule

//--- hdl/pet_display_pkg.sv
package pet_display_pkg;

    // one-hot activity codes, same values the game logic already drives
    typedef enum logic [4:0] {
        IDLE     = 5'b00001,
        SLEEPING = 5'b00010,
        EATING   = 5'b00100,
        TEACHING = 5'b01000,
        DEAD     = 5'b10000
    } pet_state_e;

    localparam int FRAME_BYTES = 1024;  // 128x64 pixels, one byte per 8-pixel slice
    localparam int ADDR_W      = 10;
    localparam int FRAME_ID_W  = 5;
    localparam int IDX_W       = 3;     // holds the longest animation (8 frames)
    localparam int ROM_ADDR_W  = FRAME_ID_W + ADDR_W;

    localparam int IDLE_FRAMES  = 6;
    localparam int SLEEP_FRAMES = 4;
    localparam int EAT_FRAMES   = 5;
    localparam int TEACH_FRAMES = 7;
    localparam int DEAD_FRAMES  = 8;

    // first frame of each animation inside the sprite ROM
    localparam logic [FRAME_ID_W-1:0] IDLE_BASE  = 5'd0;
    localparam logic [FRAME_ID_W-1:0] SLEEP_BASE = 5'd6;
    localparam logic [FRAME_ID_W-1:0] EAT_BASE   = 5'd10;
    localparam logic [FRAME_ID_W-1:0] TEACH_BASE = 5'd15;
    localparam logic [FRAME_ID_W-1:0] DEAD_BASE  = 5'd22;

    localparam int TOTAL_FRAMES = 30;
    localparam int ROM_DEPTH    = TOTAL_FRAMES * FRAME_BYTES;

    localparam int COL_BYTES = 8;                 // bytes per column in the address map
    localparam int OFS_W     = $clog2(COL_BYTES);
    localparam int COL_W     = ADDR_W - OFS_W;

    localparam int HAPPY_COL    = 8;
    localparam int HUNGER_COL   = 18;
    localparam int SLEEP_COL    = 28;
    localparam int BAR_COLS     = 5;  // columns covered by one bar
    localparam int BAR_SEGMENTS = 5;  // segments sit at byte offsets 1 to 5

    localparam logic [7:0] SEG_FULL = 8'hEE;
    localparam logic [7:0] SEG_HALF = 8'hE0;

    // segment s lights full above 110-20s and half above 100-20s
    localparam int SEG_FULL_BASE = 110;
    localparam int SEG_HALF_BASE = 100;
    localparam int SEG_STEP      = 20;

    localparam int MOOD_HIGH = 80;
    localparam int MOOD_LOW  = 10;
    localparam int MOOD_WARN = 20;

    localparam logic [IDX_W-1:0] MOOD_CONTENT  = 3'd0;
    localparam logic [IDX_W-1:0] MOOD_HUNGRY   = 3'd1;
    localparam logic [IDX_W-1:0] MOOD_SAD      = 3'd2;
    localparam logic [IDX_W-1:0] MOOD_PLAIN    = 3'd3;
    localparam logic [IDX_W-1:0] MOOD_WORRIED  = 3'd4;
    localparam logic [IDX_W-1:0] MOOD_TIRED    = 3'd5;

    localparam string SPRITE_FILE = "sprites.hex";

    typedef struct packed {
        logic [7:0] happiness;
        logic [7:0] hunger;
        logic [7:0] sleep;
    } stats_t;

    typedef struct packed {
        logic [FRAME_ID_W-1:0] frame_id;
        logic [ADDR_W-1:0]     byte_addr;
        logic                  show_bars;
        stats_t                stats;
    } frame_req_t;

    typedef struct packed {
        logic [7:0]        data;
        logic [ADDR_W-1:0] byte_addr;
        logic              show_bars;
        stats_t            stats;
    } rom_word_t;

endpackage
